/* hdl/xfer_dist_pkg.sv */
// ======================================
// Distributor sizes and shared types
// ======================================

package xfer_dist_pkg;

  // Symbol lanes offered on the push side per cycle
  localparam int num_symbols = 4;

  // Bits per symbol
  localparam int symbol_width = 8;

  // Independent output flows, never fewer than the symbol lanes
  localparam int num_flows = 6;

  // Enough bits to count 0 to num_symbols
  localparam int count_width = $clog2(num_symbols + 1);

  // Bits to index one flow, used by the priority pointer
  localparam int flow_idx_width = $clog2(num_flows);

  // Elaboration check of the lane/flow relation, evaluated in the core
  localparam bit flow_cfg_ok = (num_flows >= num_symbols);

  // Push counts, grant allowance and grant count
  typedef logic [count_width-1:0] count_t;

  typedef logic [flow_idx_width-1:0] flow_idx_t;

endpackage

/* hdl/dist_arb_if.sv */
// ======================================
// Core to arbiter link
// ======================================

`timescale 1ns/1ps

interface dist_arb_if;
  import xfer_dist_pkg::*;

  // Core side: one request per ready flow, and a cap on grants
  logic [num_flows-1:0] request;
  count_t grant_allowed;
  logic enable_priority_update;

  // Arbiter side
  logic [num_flows-1:0] grant;
  // Lane j picks the j-th granted flow in rotation order
  logic [num_symbols-1:0][num_flows-1:0] grant_ordered;
  count_t grant_count;

  modport core (
    output request,
    output grant_allowed,
    output enable_priority_update,
    input  grant,
    input  grant_ordered,
    input  grant_count
  );

  modport arbiter (
    input  request,
    input  grant_allowed,
    input  enable_priority_update,
    output grant,
    output grant_ordered,
    output grant_count
  );

endinterface

/* hdl/multi_grant_rr_arbiter.sv */
// ======================================
// Multi-grant round-robin arbiter
// ======================================

`timescale 1ns/1ps

module multi_grant_rr_arbiter (
  input logic clk,
  input logic rst,
  dist_arb_if.arbiter arb
);
  import xfer_dist_pkg::*;

  // Flow that has highest priority this cycle
  flow_idx_t priority_ptr;
  // Flow just after the last one granted this cycle
  flow_idx_t next_ptr;
  logic any_grant;

  // Circular scan starting at the pointer.
  // Grants go to the first requesters found, up to the allowance,
  // and lane order follows scan order.
  always_comb begin
    int flow;
    int given;

    arb.grant = '0;
    arb.grant_ordered = '0;
    next_ptr = priority_ptr;
    given = 0;

    for (int k = 0; k < num_flows; k++) begin
      flow = (int'(priority_ptr) + k) % num_flows;
      if (arb.request[flow] &&
          (given < int'(arb.grant_allowed)) &&
          (given < num_symbols)) begin
        arb.grant[flow] = 1'b1;
        arb.grant_ordered[given][flow] = 1'b1;
        given = given + 1;
        // Rotation resumes after this flow next time
        next_ptr = flow_idx_t'((flow + 1) % num_flows);
      end
    end

    arb.grant_count = count_t'(given);
  end

  assign any_grant = |arb.grant;

  // Pointer only moves when something was actually granted
  always_ff @(posedge clk) begin
    if (rst) begin
      priority_ptr <= '0;
    end else if (arb.enable_priority_update && any_grant) begin
      priority_ptr <= next_ptr;
    end
  end

  // Grants may only land on flows that asked for one
  grant_subset_of_request_a : assert property (
    @(posedge clk) disable iff (rst)
    (arb.grant & ~arb.request) == '0
  ) else $error("arbiter granted a flow without a request");

  // Reported count agrees with the grant vector seen by the core
  grant_count_matches_grant_a : assert property (
    @(posedge clk) disable iff (rst)
    int'(arb.grant_count) == $countones(arb.grant)
  ) else $error("grant_count does not match number of grants");

endmodule

/* hdl/multi_xfer_distributor_core.sv */
// ======================================
// Multi-transfer distributor core
// ======================================

`timescale 1ns/1ps

module multi_xfer_distributor_core (
  input  logic clk,
  input  logic rst,
  input  xfer_dist_pkg::count_t push_sendable,
  output xfer_dist_pkg::count_t push_receivable,
  input  logic [xfer_dist_pkg::num_symbols-1:0][xfer_dist_pkg::symbol_width-1:0]
    push_data,
  output logic [xfer_dist_pkg::num_flows-1:0] pop_valid,
  input  logic [xfer_dist_pkg::num_flows-1:0] pop_ready,
  output logic [xfer_dist_pkg::num_flows-1:0][xfer_dist_pkg::symbol_width-1:0]
    pop_data,
  dist_arb_if.core arb
);
  import xfer_dist_pkg::*;

  // Per flow, which push lane feeds it
  logic [num_flows-1:0][num_symbols-1:0] lane_sel;

  // Need at least as many flows as lanes so every symbol can go somewhere
  if (!flow_cfg_ok) begin : gen_bad_cfg
    $error("num_flows must be at least num_symbols");
  end

  // Ready flows compete, the offered count caps the grants
  assign arb.request = pop_ready;
  assign arb.grant_allowed = push_sendable;
  // Allowance and requests already qualify the update
  assign arb.enable_priority_update = 1'b1;

  assign pop_valid = arb.grant;
  assign push_receivable = arb.grant_count;

  // Flip lane-major ordered grants into flow-major selects
  for (genvar f = 0; f < num_flows; f++) begin : gen_lane_sel
    for (genvar j = 0; j < num_symbols; j++) begin : gen_lane
      assign lane_sel[f][j] = arb.grant_ordered[j][f];
    end
  end

  // AND-OR mux per flow, zero when the flow was not granted
  always_comb begin
    for (int f = 0; f < num_flows; f++) begin
      pop_data[f] = '0;
      for (int j = 0; j < num_symbols; j++) begin
        pop_data[f] |= push_data[j] & {symbol_width{lane_sel[f][j]}};
      end
    end
  end

  grant_count_within_allowed_a : assert property (
    @(posedge clk) disable iff (rst)
    arb.grant_count <= arb.grant_allowed
  ) else $error("arbiter granted more than allowed");

  // A flow never takes two lanes at once
  for (genvar f = 0; f < num_flows; f++) begin : gen_sel_checks
    lane_sel_onehot0_a : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(lane_sel[f])
    ) else $error("flow %0d selects more than one lane", f);
  end

  // No back-pressure on the pop side
  pop_valid_needs_ready_a : assert property (
    @(posedge clk) disable iff (rst)
    (pop_valid & ~pop_ready) == '0
  ) else $error("pop_valid raised on a flow that is not ready");

  push_receivable_within_ready_a : assert property (
    @(posedge clk) disable iff (rst)
    int'(push_receivable) <= $countones(pop_ready)
  ) else $error("push_receivable exceeds ready flows");

endmodule

/* hdl/xfer_distributor.sv */
// ======================================
// Multi-transfer distributor top
// ======================================

`timescale 1ns/1ps

module xfer_distributor (
  input  logic clk,
  input  logic rst,

  // Push side, valid lanes packed low
  input  xfer_dist_pkg::count_t push_sendable,
  output xfer_dist_pkg::count_t push_receivable,
  input  logic [xfer_dist_pkg::num_symbols-1:0][xfer_dist_pkg::symbol_width-1:0]
    push_data,

  // Pop side, one symbol per flow per cycle
  output logic [xfer_dist_pkg::num_flows-1:0] pop_valid,
  input  logic [xfer_dist_pkg::num_flows-1:0] pop_ready,
  output logic [xfer_dist_pkg::num_flows-1:0][xfer_dist_pkg::symbol_width-1:0]
    pop_data
);

  dist_arb_if arb_if ();

  multi_xfer_distributor_core u_core (
    .clk             (clk),
    .rst             (rst),
    .push_sendable   (push_sendable),
    .push_receivable (push_receivable),
    .push_data       (push_data),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .pop_data        (pop_data),
    .arb             (arb_if.core)
  );

  // Holds the only state, the rotation pointer
  multi_grant_rr_arbiter u_arbiter (
    .clk (clk),
    .rst (rst),
    .arb (arb_if.arbiter)
  );

endmodule

/* test/tb_xfer_distributor.sv */
// ========================================
// Distributor testbench
// ========================================

`timescale 1ns/1ps

module tb_xfer_distributor;
  import xfer_dist_pkg::*;

  localparam int clk_period = 4;
  localparam int reset_cycles = 5;
  localparam int num_directed = 24;
  localparam int num_random = 200;
  localparam int margin_cycles = 20;

  logic clk;
  logic rst;
  count_t push_sendable;
  count_t push_receivable;
  logic [num_symbols-1:0][symbol_width-1:0] push_data;
  logic [num_flows-1:0] pop_valid;
  logic [num_flows-1:0] pop_ready;
  logic [num_flows-1:0][symbol_width-1:0] pop_data;

  // Directed rows with hand-worked expected grants
  count_t tbl_sendable [num_directed];
  logic [num_flows-1:0] tbl_ready [num_directed];
  logic [num_symbols*symbol_width-1:0] tbl_data [num_directed];
  logic [num_flows-1:0] tbl_valid [num_directed];
  count_t tbl_recv [num_directed];
  int fill_idx;

  // Reference model state and predictions
  int model_ptr;
  int exp_next_ptr;
  logic [num_flows-1:0] exp_valid;
  logic [num_flows-1:0][symbol_width-1:0] exp_data;
  count_t exp_recv;

  int errors;
  int seed;
  logic [31:0] rnd;
  count_t rand_sendable;
  logic [num_flows-1:0] rand_ready;
  logic [31:0] rand_data;

  xfer_distributor DUT (
    .clk             (clk),
    .rst             (rst),
    .push_sendable   (push_sendable),
    .push_receivable (push_receivable),
    .push_data       (push_data),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .pop_data        (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic add_row(input count_t s, input logic [num_flows-1:0] r,
                         input logic [31:0] d, input logic [num_flows-1:0] v,
                         input count_t n);
    tbl_sendable[fill_idx] = s;
    tbl_ready[fill_idx] = r;
    tbl_data[fill_idx] = d;
    tbl_valid[fill_idx] = v;
    tbl_recv[fill_idx] = n;
    fill_idx++;
  endtask

  // Walk the flows from the model pointer, hand lane k to the k-th ready one
  task automatic predict(input int sendable, input logic [num_flows-1:0] ready,
                         input logic [num_symbols-1:0][symbol_width-1:0] data);
    int taken;
    int flow;
    int limit;
    exp_valid = '0;
    exp_data = '0;
    exp_next_ptr = model_ptr;
    taken = 0;
    limit = (sendable < num_symbols) ? sendable : num_symbols;
    for (int step = 0; step < num_flows; step++) begin
      flow = (model_ptr + step) % num_flows;
      if (ready[flow] && taken < limit) begin
        exp_valid[flow] = 1'b1;
        exp_data[flow] = data[taken];
        taken++;
        exp_next_ptr = (flow + 1) % num_flows;
      end
    end
    exp_recv = count_t'(taken);
  endtask

  task automatic apply_row(input string name, input count_t sendable,
                           input logic [num_flows-1:0] ready,
                           input logic [num_symbols*symbol_width-1:0] data,
                           input bit has_table, input logic [num_flows-1:0] tvalid,
                           input count_t trecv);
    @(posedge clk);
    #1;
    push_sendable = sendable;
    pop_ready = ready;
    push_data = data;
    predict(int'(sendable), ready, data);
    // Outputs settle combinationally, sample just before the next edge
    #2;
    check_value({name, " pop_valid"}, 64'(exp_valid), 64'(pop_valid));
    check_value({name, " pop_data"}, 64'(exp_data), 64'(pop_data));
    check_value({name, " push_receivable"}, 64'(exp_recv), 64'(push_receivable));
    if (has_table) begin
      check_value({name, " table pop_valid"}, 64'(tvalid), 64'(pop_valid));
      check_value({name, " table push_receivable"}, 64'(trecv), 64'(push_receivable));
    end
    if (exp_valid != '0) begin
      model_ptr = exp_next_ptr;
    end
  endtask

  task automatic fill_table();
    fill_idx = 0;
    // Nothing offered right after reset
    add_row(3'd0, 6'b111111, 32'h11223344, 6'b000000, 3'd0);
    add_row(3'd0, 6'b101010, 32'h55667788, 6'b000000, 3'd0);
    // Single symbols with all flows ready, two idle rows mixed in
    add_row(3'd1, 6'b111111, 32'h000000a0, 6'b000001, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000a1, 6'b000010, 3'd1);
    add_row(3'd0, 6'b111111, 32'h000000ee, 6'b000000, 3'd0);
    add_row(3'd1, 6'b111111, 32'h000000a2, 6'b000100, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000a3, 6'b001000, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000a4, 6'b010000, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000a5, 6'b100000, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000b0, 6'b000001, 3'd1);
    add_row(3'd0, 6'b111111, 32'h000000ef, 6'b000000, 3'd0);
    add_row(3'd1, 6'b111111, 32'h000000b1, 6'b000010, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000b2, 6'b000100, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000b3, 6'b001000, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000b4, 6'b010000, 3'd1);
    add_row(3'd1, 6'b111111, 32'h000000b5, 6'b100000, 3'd1);
    // Fewer ready flows than offered symbols
    add_row(3'd4, 6'b000101, 32'hc3c2c1c0, 6'b000101, 3'd2);
    add_row(3'd3, 6'b100001, 32'hd3d2d1d0, 6'b100001, 3'd2);
    // More ready flows than offered symbols
    add_row(3'd2, 6'b111111, 32'he3e2e1e0, 6'b000110, 3'd2);
    add_row(3'd3, 6'b110110, 32'hf3f2f1f0, 6'b110010, 3'd3);
    add_row(3'd4, 6'b111111, 32'h13121110, 6'b111100, 3'd4);
    add_row(3'd1, 6'b000000, 32'h23222120, 6'b000000, 3'd0);
    add_row(3'd4, 6'b111111, 32'h33323130, 6'b001111, 3'd4);
    add_row(3'd2, 6'b001100, 32'h43424140, 6'b001100, 3'd2);
  endtask

  initial begin
    rst = 1'b1;
    push_sendable = '0;
    pop_ready = '0;
    push_data = '0;
    errors = 0;
    seed = 73356;
    model_ptr = 0;
    fill_table();

    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < num_directed; i++) begin
      apply_row($sformatf("directed %0d", i), tbl_sendable[i], tbl_ready[i],
                tbl_data[i], 1'b1, tbl_valid[i], tbl_recv[i]);
    end

    for (int i = 0; i < num_random; i++) begin
      rnd = $random(seed);
      rand_sendable = count_t'(rnd % 32'd5);
      rnd = $random(seed);
      rand_ready = rnd[num_flows-1:0];
      rand_data = $random(seed);
      apply_row($sformatf("random %0d", i), rand_sendable, rand_ready,
                rand_data, 1'b0, '0, '0);
    end

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Covers every row plus reset with some slack
  initial begin
    #((num_directed + num_random + reset_cycles + margin_cycles) * clk_period);
    $display("Run timed out before all rows were applied");
    $display("Regression failed");
    $finish;
  end

endmodule

/* tb.f */
hdl/xfer_dist_pkg.sv
hdl/dist_arb_if.sv
hdl/multi_grant_rr_arbiter.sv
hdl/multi_xfer_distributor_core.sv
hdl/xfer_distributor.sv
test/tb_xfer_distributor.sv

/* Makefile */
# Verilator build and run for the distributor testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_xfer_distributor
FILELIST   ?= tb.f
LOG        ?= sim.log
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides pass or fail
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
